// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // integer and instruction widths
    localparam int REG_WIDTH  = 64;
    localparam int INST_WIDTH = 32;

    typedef logic [REG_WIDTH-1:0]  reg_t;
    typedef logic [INST_WIDTH-1:0] inst_t;

    // access size codes, funct3 meaning
    typedef logic [2:0] mem_op_t;

    localparam mem_op_t MEM_B   = 3'd0;
    localparam mem_op_t MEM_H   = 3'd1;
    localparam mem_op_t MEM_W   = 3'd2;
    localparam mem_op_t MEM_D   = 3'd3;
    localparam mem_op_t MEM_BU  = 3'd4;
    localparam mem_op_t MEM_HU  = 3'd5;
    localparam mem_op_t MEM_WU  = 3'd6;
    localparam mem_op_t MEM_BAD = 3'd7;

    // write-back source
    typedef logic [1:0] reg_src_t;

    localparam reg_src_t SRC_ALU = 2'd0;
    localparam reg_src_t SRC_MEM = 2'd1;
    localparam reg_src_t SRC_CSR = 2'd2;

    // local data memory, 64-bit words
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    // everything carried through the LSU stage
    typedef struct packed {
        logic     mem_wr;
        mem_op_t  mem_op;
        reg_t     rs2;
        inst_t    inst;
        reg_t     pc;
        reg_t     alu_res;
        reg_src_t reg_src;
        logic     reg_wr;
        logic     is_ecall;
        logic     is_mret;
        logic     is_csr;
        reg_t     rs1;
        reg_t     csr_rdata;
    } lsu_payload_t;

    // what is left once the write-back value is chosen
    typedef struct packed {
        inst_t inst;
        reg_t  pc;
        logic  reg_wr;
        reg_t  wb_data;
        logic  is_ecall;
        logic  is_mret;
        logic  is_csr;
        // csr write data
        reg_t  rs1;
    } wbu_payload_t;

endpackage

`default_nettype wire

// ==== hw/pipe_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_stage_reg #(
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic i_arst_n,
    input  wire logic i_flush,
    input  wire logic i_in_valid,
    input  wire T     i_in_data,
    input  wire logic i_out_ready,
    output logic      o_allow_in,
    output logic      o_valid,
    output T          o_data
);

    logic valid_q;
    logic take;
    T     data_q;

    // accept when empty or when the consumer drains us this cycle
    assign o_allow_in = !valid_q || i_out_ready;
    assign take       = i_in_valid && o_allow_in && !i_flush;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else if (o_allow_in) begin
            valid_q <= i_in_valid;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            data_q <= '0;
        end else if (take) begin
            data_q <= i_in_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

    // a stalled item must not change under the consumer
    a_hold_stable : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_valid && !i_out_ready |=> $stable(o_data)
    ) else $error("stage payload changed while stalled");

endmodule

`default_nettype wire

// ==== hw/lsu_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_regs (
    input  wire logic                  clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_flush,
    input  wire logic                  i_exu_valid,
    // memory control
    input  wire logic                  i_mem_wr,
    input  wire core_pkg::mem_op_t     i_mem_op,
    input  wire core_pkg::reg_t        i_rs2,
    // inst and pc
    input  wire core_pkg::inst_t       i_inst,
    input  wire core_pkg::reg_t        i_pc,
    // forwarded to write-back
    input  wire core_pkg::reg_t        i_alu_res,
    input  wire core_pkg::reg_src_t    i_reg_src,
    input  wire logic                  i_reg_wr,
    input  wire logic                  i_is_ecall,
    input  wire logic                  i_is_mret,
    input  wire logic                  i_is_csr,
    input  wire core_pkg::reg_t        i_rs1,
    input  wire core_pkg::reg_t        i_csr_rdata,
    input  wire logic                  i_lsu_ready,
    output logic                       o_allow_in,
    output logic                       o_lsu_valid,
    output core_pkg::lsu_payload_t     o_lsu
);

    import core_pkg::*;

    lsu_payload_t lsu_in;

    // pack the loose execute ports into the stage payload
    always_comb begin
        lsu_in.mem_wr    = i_mem_wr;
        lsu_in.mem_op    = i_mem_op;
        lsu_in.rs2       = i_rs2;
        lsu_in.inst      = i_inst;
        lsu_in.pc        = i_pc;
        lsu_in.alu_res   = i_alu_res;
        lsu_in.reg_src   = i_reg_src;
        lsu_in.reg_wr    = i_reg_wr;
        lsu_in.is_ecall  = i_is_ecall;
        lsu_in.is_mret   = i_is_mret;
        lsu_in.is_csr    = i_is_csr;
        lsu_in.rs1       = i_rs1;
        lsu_in.csr_rdata = i_csr_rdata;
    end

    pipe_stage_reg #(
        .T (lsu_payload_t)
    ) u_stage (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .i_in_valid  (i_exu_valid),
        .i_in_data   (lsu_in),
        .i_out_ready (i_lsu_ready),
        .o_allow_in  (o_allow_in),
        .o_valid     (o_lsu_valid),
        .o_data      (o_lsu)
    );

    // a store never also writes back load data
    a_no_store_load : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_lsu_valid |-> !(o_lsu.mem_wr && o_lsu.reg_wr && o_lsu.reg_src == SRC_MEM)
    ) else $error("store item also marked as load write-back");

endmodule

`default_nettype wire

// ==== hw/load_store_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,
    input  wire logic                   i_flush,
    input  wire logic                   i_lsu_valid,
    input  wire core_pkg::lsu_payload_t i_lsu,
    input  wire logic                   i_next_ready,
    output core_pkg::reg_t              o_load_data
);

    import core_pkg::*;

    reg_t                 mem [DMEM_WORDS];
    logic [DMEM_AW-1:0]   word_idx;
    logic [2:0]           byte_off;
    logic [7:0]           byte_mask;
    reg_t                 store_data;
    reg_t                 load_shifted;
    logic                 store_en;
    logic                 is_access;
    logic                 misaligned;

    assign word_idx = i_lsu.alu_res[DMEM_AW+2:3];
    assign byte_off = i_lsu.alu_res[2:0];

    // store goes on the edge the item moves on to write-back
    assign store_en   = i_lsu_valid && i_next_ready && !i_flush && i_lsu.mem_wr;
    assign store_data = i_lsu.rs2 << {byte_off, 3'b000};

    always_comb begin
        case (i_lsu.mem_op[1:0])
            2'd0:    byte_mask = 8'h01 << byte_off;
            2'd1:    byte_mask = 8'h03 << byte_off;
            2'd2:    byte_mask = 8'h0f << byte_off;
            default: byte_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (store_en) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_mask[b]) begin
                    mem[word_idx][b*8 +: 8] <= store_data[b*8 +: 8];
                end
            end
        end
    end

    // load path, shift the addressed lane down then extend
    assign load_shifted = mem[word_idx] >> {byte_off, 3'b000};

    always_comb begin
        case (i_lsu.mem_op)
            MEM_B:   o_load_data = {{(REG_WIDTH-8){load_shifted[7]}}, load_shifted[7:0]};
            MEM_H:   o_load_data = {{(REG_WIDTH-16){load_shifted[15]}}, load_shifted[15:0]};
            MEM_W:   o_load_data = {{(REG_WIDTH-32){load_shifted[31]}}, load_shifted[31:0]};
            MEM_D:   o_load_data = load_shifted;
            MEM_BU:  o_load_data = {{(REG_WIDTH-8){1'b0}}, load_shifted[7:0]};
            MEM_HU:  o_load_data = {{(REG_WIDTH-16){1'b0}}, load_shifted[15:0]};
            MEM_WU:  o_load_data = {{(REG_WIDTH-32){1'b0}}, load_shifted[31:0]};
            default: o_load_data = load_shifted;
        endcase
    end

    // natural alignment per size
    always_comb begin
        case (i_lsu.mem_op[1:0])
            2'd0:    misaligned = 1'b0;
            2'd1:    misaligned = byte_off[0];
            2'd2:    misaligned = |byte_off[1:0];
            default: misaligned = |byte_off;
        endcase
    end

    assign is_access = i_lsu.mem_wr || (i_lsu.reg_wr && i_lsu.reg_src == SRC_MEM);

    // Misaligned access is not handled here, the execute side must trap it.
    a_aligned : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_lsu_valid && is_access |-> !misaligned && i_lsu.mem_op != MEM_BAD
    ) else $error("misaligned or illegal memory access");

endmodule

`default_nettype wire

// ==== hw/wbu_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module wbu_regs (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,
    input  wire logic                   i_flush,
    input  wire logic                   i_lsu_valid,
    input  wire core_pkg::lsu_payload_t i_lsu,
    input  wire core_pkg::reg_t         i_load_data,
    input  wire logic                   i_wb_ready,
    output logic                        o_allow_in,
    output logic                        o_wb_valid,
    output core_pkg::wbu_payload_t      o_wb
);

    import core_pkg::*;

    reg_t         wb_data;
    wbu_payload_t wbu_in;

    // pick the write-back value before it is registered
    always_comb begin
        case (i_lsu.reg_src)
            SRC_ALU: wb_data = i_lsu.alu_res;
            SRC_MEM: wb_data = i_load_data;
            SRC_CSR: wb_data = i_lsu.csr_rdata;
            default: wb_data = i_lsu.alu_res;
        endcase
    end

    always_comb begin
        wbu_in.inst     = i_lsu.inst;
        wbu_in.pc       = i_lsu.pc;
        wbu_in.reg_wr   = i_lsu.reg_wr;
        wbu_in.wb_data  = wb_data;
        wbu_in.is_ecall = i_lsu.is_ecall;
        wbu_in.is_mret  = i_lsu.is_mret;
        wbu_in.is_csr   = i_lsu.is_csr;
        wbu_in.rs1      = i_lsu.rs1;
    end

    pipe_stage_reg #(
        .T (wbu_payload_t)
    ) u_stage (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .i_in_valid  (i_lsu_valid),
        .i_in_data   (wbu_in),
        .i_out_ready (i_wb_ready),
        .o_allow_in  (o_allow_in),
        .o_valid     (o_wb_valid),
        .o_data      (o_wb)
    );

endmodule

`default_nettype wire

// ==== hw/lsu_subsystem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_subsystem_top (
    input  wire logic               clk,
    input  wire logic               i_arst_n,
    input  wire logic               i_flush,
    // execute side
    input  wire logic               i_exu_valid,
    input  wire logic               i_mem_wr,
    input  wire core_pkg::mem_op_t  i_mem_op,
    input  wire core_pkg::reg_t     i_rs2,
    input  wire core_pkg::inst_t    i_inst,
    input  wire core_pkg::reg_t     i_pc,
    input  wire core_pkg::reg_t     i_alu_res,
    input  wire core_pkg::reg_src_t i_reg_src,
    input  wire logic               i_reg_wr,
    input  wire logic               i_is_ecall,
    input  wire logic               i_is_mret,
    input  wire logic               i_is_csr,
    input  wire core_pkg::reg_t     i_rs1,
    input  wire core_pkg::reg_t     i_csr_rdata,
    output logic                    o_lsu_allow_in,
    // write-back side
    input  wire logic               i_wb_ready,
    output logic                    o_wb_valid,
    output core_pkg::inst_t         o_wb_inst,
    output core_pkg::reg_t          o_wb_pc,
    output logic                    o_wb_reg_wr,
    output core_pkg::reg_t          o_wb_data,
    output logic                    o_wb_is_ecall,
    output logic                    o_wb_is_mret,
    output logic                    o_wb_is_csr,
    output core_pkg::reg_t          o_wb_csr_wdata
);

    import core_pkg::*;

    logic         lsu_valid;
    lsu_payload_t lsu;
    reg_t         load_data;
    logic         wbu_allow_in;
    wbu_payload_t wb;

    lsu_regs u_lsu_regs (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .i_exu_valid (i_exu_valid),
        .i_mem_wr    (i_mem_wr),
        .i_mem_op    (i_mem_op),
        .i_rs2       (i_rs2),
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_alu_res   (i_alu_res),
        .i_reg_src   (i_reg_src),
        .i_reg_wr    (i_reg_wr),
        .i_is_ecall  (i_is_ecall),
        .i_is_mret   (i_is_mret),
        .i_is_csr    (i_is_csr),
        .i_rs1       (i_rs1),
        .i_csr_rdata (i_csr_rdata),
        .i_lsu_ready (wbu_allow_in),
        .o_allow_in  (o_lsu_allow_in),
        .o_lsu_valid (lsu_valid),
        .o_lsu       (lsu)
    );

    load_store_unit u_lsu (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (i_flush),
        .i_lsu_valid  (lsu_valid),
        .i_lsu        (lsu),
        .i_next_ready (wbu_allow_in),
        .o_load_data  (load_data)
    );

    wbu_regs u_wbu_regs (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .i_lsu_valid (lsu_valid),
        .i_lsu       (lsu),
        .i_load_data (load_data),
        .i_wb_ready  (i_wb_ready),
        .o_allow_in  (wbu_allow_in),
        .o_wb_valid  (o_wb_valid),
        .o_wb        (wb)
    );

    // unpack for the register and csr files
    assign o_wb_inst      = wb.inst;
    assign o_wb_pc        = wb.pc;
    assign o_wb_reg_wr    = wb.reg_wr;
    assign o_wb_data      = wb.wb_data;
    assign o_wb_is_ecall  = wb.is_ecall;
    assign o_wb_is_mret   = wb.is_mret;
    assign o_wb_is_csr    = wb.is_csr;
    assign o_wb_csr_wdata = wb.rs1;

endmodule

`default_nettype wire

// ==== tests/tb_lsu_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_subsystem;

    import core_pkg::*;

    localparam int          N_CYCLES    = 2000;
    localparam int          CYCLE_LIMIT = 2 * N_CYCLES;
    localparam logic [31:0] LFSR_SEED   = 32'hc9241f0f;
    localparam logic [31:0] LFSR_POLY   = 32'h80200003;

    logic         clk = 1'b0;
    logic         i_arst_n;
    logic         i_flush;
    logic         i_exu_valid;
    logic         i_wb_ready;
    lsu_payload_t drv;
    logic         o_lsu_allow_in;
    logic         o_wb_valid;
    inst_t        o_wb_inst;
    reg_t         o_wb_pc;
    logic         o_wb_reg_wr;
    reg_t         o_wb_data;
    logic         o_wb_is_ecall;
    logic         o_wb_is_mret;
    logic         o_wb_is_csr;
    reg_t         o_wb_csr_wdata;

    // model state with one slot per stage and a mirror of the data memory
    logic         m_lsu_v;
    logic         m_wb_v;
    lsu_payload_t m_lsu;
    wbu_payload_t m_wb;
    reg_t         mirror [DMEM_WORDS];
    logic [31:0]  lfsr;
    int           cycles = 0;

    always #50 clk = ~clk;

    lsu_subsystem_top dut (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (i_flush),
        .i_exu_valid    (i_exu_valid),
        .i_mem_wr       (drv.mem_wr),
        .i_mem_op       (drv.mem_op),
        .i_rs2          (drv.rs2),
        .i_inst         (drv.inst),
        .i_pc           (drv.pc),
        .i_alu_res      (drv.alu_res),
        .i_reg_src      (drv.reg_src),
        .i_reg_wr       (drv.reg_wr),
        .i_is_ecall     (drv.is_ecall),
        .i_is_mret      (drv.is_mret),
        .i_is_csr       (drv.is_csr),
        .i_rs1          (drv.rs1),
        .i_csr_rdata    (drv.csr_rdata),
        .o_lsu_allow_in (o_lsu_allow_in),
        .i_wb_ready     (i_wb_ready),
        .o_wb_valid     (o_wb_valid),
        .o_wb_inst      (o_wb_inst),
        .o_wb_pc        (o_wb_pc),
        .o_wb_reg_wr    (o_wb_reg_wr),
        .o_wb_data      (o_wb_data),
        .o_wb_is_ecall  (o_wb_is_ecall),
        .o_wb_is_mret   (o_wb_is_mret),
        .o_wb_is_csr    (o_wb_is_csr),
        .o_wb_csr_wdata (o_wb_csr_wdata)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_POLY;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // take the lanes at the offset and extend by width
    function automatic reg_t load_model(input reg_t word, input int off, input mem_op_t op);
        reg_t v;
        reg_t mask;
        int   nbits;
        nbits = 8 << op[1:0];
        mask  = (nbits == 64) ? '1 : ((reg_t'(1) << nbits) - 64'd1);
        v     = (word >> (off * 8)) & mask;
        if (!op[2] && v[nbits-1]) begin
            v = v | ~mask;
        end
        return v;
    endfunction

    task automatic store_model(input lsu_payload_t p);
        int idx;
        int off;
        idx = int'(p.alu_res[DMEM_AW+2:3]);
        off = int'(p.alu_res[2:0]);
        for (int i = 0; i < (1 << p.mem_op[1:0]); i++) begin
            mirror[idx][(off+i)*8 +: 8] = p.rs2[i*8 +: 8];
        end
    endtask

    function automatic wbu_payload_t wb_model(input lsu_payload_t p);
        wbu_payload_t w;
        reg_t         word;
        word       = mirror[int'(p.alu_res[DMEM_AW+2:3])];
        w.inst     = p.inst;
        w.pc       = p.pc;
        w.reg_wr   = p.reg_wr;
        w.is_ecall = p.is_ecall;
        w.is_mret  = p.is_mret;
        w.is_csr   = p.is_csr;
        w.rs1      = p.rs1;
        case (p.reg_src)
            SRC_MEM: w.wb_data = load_model(word, int'(p.alu_res[2:0]), p.mem_op);
            SRC_CSR: w.wb_data = p.csr_rdata;
            default: w.wb_data = p.alu_res;
        endcase
        return w;
    endfunction

    // kind 0 store, 1 load, 2 alu, 3 csr
    function automatic lsu_payload_t new_item();
        lsu_payload_t p;
        logic [1:0]   kind;
        logic [4:0]   off;
        kind        = 2'(rand_bits(2));
        p.mem_op    = mem_op_t'(rand_bits(3));
        p.rs2       = rand_bits(64);
        p.inst      = inst_t'(rand_bits(32));
        p.pc        = rand_bits(64);
        p.alu_res   = rand_bits(64);
        p.rs1       = rand_bits(64);
        p.csr_rdata = rand_bits(64);
        p.is_ecall  = 1'(rand_bits(1));
        p.is_mret   = 1'(rand_bits(1));
        p.is_csr    = 1'(rand_bits(1));
        p.reg_wr    = 1'(rand_bits(1));
        p.mem_wr    = 1'b0;
        p.reg_src   = SRC_ALU;
        case (kind)
            2'd0: begin
                p.mem_op[2] = 1'b0;
                p.mem_wr    = 1'b1;
                p.reg_wr    = 1'b0;
            end
            2'd1: begin
                if (p.mem_op == MEM_BAD) begin
                    p.mem_op = MEM_D;
                end
                p.reg_wr  = 1'b1;
                p.reg_src = SRC_MEM;
            end
            2'd3: p.reg_src = SRC_CSR;
            default: p.reg_src = SRC_ALU;
        endcase
        // small aligned window so loads see earlier stores
        if (kind < 2'd2) begin
            off       = 5'(rand_bits(5));
            off       = off & ~((5'd1 << p.mem_op[1:0]) - 5'd1);
            p.alu_res = 64'h80 + 64'(off);
        end
        return p;
    endfunction

    task automatic check_word(input string name, input reg_t got, input reg_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input logic exp_allow);
        check_flag("o_lsu_allow_in", o_lsu_allow_in, exp_allow);
        check_flag("o_wb_valid", o_wb_valid, m_wb_v);
        if (m_wb_v) begin
            check_inst("o_wb_inst", o_wb_inst, m_wb.inst);
            check_word("o_wb_pc", o_wb_pc, m_wb.pc);
            check_flag("o_wb_reg_wr", o_wb_reg_wr, m_wb.reg_wr);
            check_word("o_wb_data", o_wb_data, m_wb.wb_data);
            check_flag("o_wb_is_ecall", o_wb_is_ecall, m_wb.is_ecall);
            check_flag("o_wb_is_mret", o_wb_is_mret, m_wb.is_mret);
            check_flag("o_wb_is_csr", o_wb_is_csr, m_wb.is_csr);
            check_word("o_wb_csr_wdata", o_wb_csr_wdata, m_wb.rs1);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        lsu_payload_t item;
        logic         valid;
        logic         ready;
        logic         flush;
        logic         lsu_allow;
        logic         wb_allow;
        lfsr        = LFSR_SEED;
        drv         = '0;
        i_arst_n    = 1'b0;
        i_flush     = 1'b0;
        i_exu_valid = 1'b0;
        i_wb_ready  = 1'b0;
        m_lsu_v     = 1'b0;
        m_wb_v      = 1'b0;
        m_lsu       = '0;
        m_wb        = '0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mirror[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        #1;
        check_flag("o_wb_valid after reset", o_wb_valid, 1'b0);
        check_flag("o_wb_reg_wr after reset", o_wb_reg_wr, 1'b0);
        check_flag("o_lsu_allow_in after reset", o_lsu_allow_in, 1'b1);

        // free flow first, back-pressure from cycle 500 and flushes from 1500
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(negedge clk);
            valid = 2'(rand_bits(2)) != 2'd0;
            ready = (cyc < 500) ? 1'b1 : (2'(rand_bits(2)) != 2'd0);
            flush = (cyc >= 1500) && (4'(rand_bits(4)) == 4'd0);
            item  = new_item();
            i_exu_valid = valid;
            i_wb_ready  = ready;
            i_flush     = flush;
            drv         = item;
            #1;
            wb_allow  = !m_wb_v || ready;
            lsu_allow = !m_lsu_v || wb_allow;
            compare_outputs(lsu_allow);

            // advance the model over the coming rising edge
            if (flush) begin
                m_lsu_v = 1'b0;
                m_wb_v  = 1'b0;
            end else begin
                if (wb_allow) begin
                    if (m_lsu_v) begin
                        m_wb = wb_model(m_lsu);
                        if (m_lsu.mem_wr) begin
                            store_model(m_lsu);
                        end
                    end
                    m_wb_v = m_lsu_v;
                end
                if (lsu_allow) begin
                    m_lsu_v = valid;
                    if (valid) begin
                        m_lsu = item;
                    end
                end
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/core_pkg.sv
hw/pipe_stage_reg.sv
hw/lsu_regs.sv
hw/load_store_unit.sv
hw/wbu_regs.sv
hw/lsu_subsystem_top.sv
tests/tb_lsu_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LSU subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f \
    --top-module tb_lsu_subsystem -o tb_lsu_subsystem

./obj_dir/tb_lsu_subsystem 2>&1 | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi
